//--- hw/conspiracion_defines.svh
`ifndef CONSPIRACION_DEFINES_SVH
`define CONSPIRACION_DEFINES_SVH

// host bus
`define ADDR_W 2
`define DATA_W 8

// register map
`define REG_LEDS     0
`define REG_SWITCHES 1
`define REG_BUTTONS  2

// stable cycles needed before a debounced output moves
`define DEBOUNCE_CYCLES 8

// tiny frame, in pixel clocks and lines
`define H_ACTIVE 16
`define H_FRONT  2
`define H_SYNC   4
`define H_BACK   2

`define V_ACTIVE 8
`define V_FRONT  1
`define V_SYNC   2
`define V_BACK   1

`endif

//--- hw/conspiracion_pkg.sv
`default_nettype none

`include "conspiracion_defines.svh"

package conspiracion_pkg;

	typedef logic [`ADDR_W - 1:0] bus_addr_t;
	typedef logic [`DATA_W - 1:0] bus_data_t;

	// pixel and line counters, sized for the small frame
	typedef logic [4:0] hcount_t;
	typedef logic [3:0] vcount_t;

	typedef logic [7:0] color_t;

	typedef enum logic [1:0] {
		RUNNING,
		DRAINING,
		HALTED,
		STEPPING
	} halt_state_t;

endpackage

`default_nettype wire

//--- hw/bus_if.sv
`timescale 1ns/1ns
`default_nettype none

interface bus_if import conspiracion_pkg::*; ();

	logic      valid;
	logic      ready;
	logic      write;
	bus_addr_t addr;
	bus_data_t wdata;
	logic      rvalid;
	bus_data_t rdata;

	modport host
	(
		output valid, write, addr, wdata,
		input  ready, rvalid, rdata
	);

	modport device
	(
		input  valid, write, addr, wdata,
		output ready, rvalid, rdata
	);

endinterface

`default_nettype wire

//--- hw/debounce.sv
`timescale 1ns/1ns
`default_nettype none

`include "conspiracion_defines.svh"

module debounce
(
	input  logic clk_clk,
	input  logic rst,
	input  logic dirty,
	output logic clean
);

	localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES);
	localparam logic [CNT_W - 1:0] CNT_LAST = CNT_W'(`DEBOUNCE_CYCLES - 1);

	logic sync_0, sync_1;
	logic [CNT_W - 1:0] stable_cnt;

	always_ff @(posedge clk_clk) begin
		if (rst) begin
			sync_0 <= 1'b0;
			sync_1 <= 1'b0;
			stable_cnt <= '0;
			clean <= 1'b0;
		end else begin
			sync_0 <= dirty;
			sync_1 <= sync_0;

			// any bounce back to the old level restarts the window
			if (sync_1 == clean)
				stable_cnt <= '0;
			else if (stable_cnt == CNT_LAST) begin
				clean <= sync_1;
				stable_cnt <= '0;
			end else
				stable_cnt <= stable_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- hw/halt_gate.sv
`timescale 1ns/1ns
`default_nettype none

module halt_gate
	import conspiracion_pkg::*;
(
	input  logic  clk_clk,
	input  logic  rst,
	input  logic  cpu_halt,
	input  logic  step,
	output logic  cpu_halted,

	bus_if.device up,
	bus_if.host   down
);

	halt_state_t state, next_state;
	logic pass, xfer, pending_rd, step_q, step_rise;

	assign step_rise = step & ~step_q;
	assign pass = (state == RUNNING && !cpu_halt) || state == STEPPING;
	assign xfer = down.valid & down.ready;

	assign down.valid = up.valid & pass;
	assign down.write = up.write;
	assign down.addr = up.addr;
	assign down.wdata = up.wdata;

	// zero-latency path back to the host
	assign up.ready = down.ready & pass;
	assign up.rvalid = down.rvalid;
	assign up.rdata = down.rdata;

	always_comb begin
		next_state = state;

		unique case (state)
			RUNNING:
				if (cpu_halt)
					next_state = pending_rd ? DRAINING : HALTED;

			DRAINING:
				if (!pending_rd)
					next_state = HALTED;

			HALTED:
				if (!cpu_halt)
					next_state = RUNNING;
				else if (step_rise)
					next_state = STEPPING;

			STEPPING:
				if (!cpu_halt)
					next_state = RUNNING;
				else if (xfer)
					next_state = down.write ? HALTED : DRAINING;
		endcase
	end

	always_ff @(posedge clk_clk) begin
		if (rst) begin
			state <= RUNNING;
			pending_rd <= 1'b0;
			step_q <= 1'b0;
			cpu_halted <= 1'b0;
		end else begin
			state <= next_state;
			// response always lands one cycle after a read
			pending_rd <= xfer & ~down.write;
			step_q <= step;
			// stays up across single steps, drops only when running again
			cpu_halted <= next_state == HALTED || (cpu_halted && next_state != RUNNING);
		end
	end

endmodule

`default_nettype wire

//--- hw/pio_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "conspiracion_defines.svh"

module pio_regs
	import conspiracion_pkg::*;
(
	input  logic      clk_clk,
	input  logic      rst,

	bus_if.device     bus,

	input  bus_data_t switches,
	input  logic      button,
	output bus_data_t leds
);

	localparam bus_addr_t ADDR_LEDS = bus_addr_t'(`REG_LEDS);
	localparam bus_addr_t ADDR_SWITCHES = bus_addr_t'(`REG_SWITCHES);
	localparam bus_addr_t ADDR_BUTTONS = bus_addr_t'(`REG_BUTTONS);

	logic xfer, wr_xfer, button_q, pressed;

	assign xfer = bus.valid & bus.ready;
	assign wr_xfer = xfer & bus.write;

	always_ff @(posedge clk_clk) begin
		if (rst) begin
			bus.ready <= 1'b0;
			bus.rvalid <= 1'b0;
			leds <= '0;
			button_q <= 1'b0;
			pressed <= 1'b0;
		end else begin
			bus.ready <= 1'b1;
			bus.rvalid <= xfer & ~bus.write;
			button_q <= button;

			if (wr_xfer && bus.addr == ADDR_LEDS)
				leds <= bus.wdata;

			// write 1 to clear, a new press wins
			if (wr_xfer && bus.addr == ADDR_BUTTONS && bus.wdata[1])
				pressed <= 1'b0;
			if (button && !button_q)
				pressed <= 1'b1;
		end
	end

	always_ff @(posedge clk_clk) begin
		if (xfer && !bus.write) begin
			unique case (bus.addr)
				ADDR_LEDS:
					bus.rdata <= leds;
				ADDR_SWITCHES:
					bus.rdata <= switches;
				ADDR_BUTTONS:
					bus.rdata <= bus_data_t'({pressed, button});
				default:
					bus.rdata <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/vga_timing.sv
`timescale 1ns/1ns
`default_nettype none

`include "conspiracion_defines.svh"

module vga_timing
	import conspiracion_pkg::*;
(
	input  logic      clk_clk,
	input  logic      rst,
	input  bus_data_t leds,
	output logic      hsync,
	output logic      vsync,
	output logic      blank_n,
	output color_t    r,
	output color_t    g,
	output color_t    b
);

	localparam hcount_t H_SYNC_START = hcount_t'(`H_ACTIVE + `H_FRONT);
	localparam hcount_t H_SYNC_END = hcount_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
	localparam hcount_t H_LAST = hcount_t'(`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK - 1);
	localparam hcount_t H_ACT = hcount_t'(`H_ACTIVE);

	localparam vcount_t V_SYNC_START = vcount_t'(`V_ACTIVE + `V_FRONT);
	localparam vcount_t V_SYNC_END = vcount_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);
	localparam vcount_t V_LAST = vcount_t'(`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK - 1);
	localparam vcount_t V_ACT = vcount_t'(`V_ACTIVE);

	hcount_t hcount;
	vcount_t vcount;
	logic active;

	assign active = hcount < H_ACT && vcount < V_ACT;

	always_ff @(posedge clk_clk) begin
		if (rst) begin
			hcount <= '0;
			vcount <= '0;
		end else if (hcount == H_LAST) begin
			hcount <= '0;
			vcount <= vcount == V_LAST ? '0 : vcount + vcount_t'(1);
		end else
			hcount <= hcount + hcount_t'(1);
	end

	// decoded outputs trail the counters by one cycle
	always_ff @(posedge clk_clk) begin
		if (rst) begin
			hsync <= 1'b1;
			vsync <= 1'b1;
			blank_n <= 1'b0;
		end else begin
			hsync <= !(hcount >= H_SYNC_START && hcount < H_SYNC_END);
			vsync <= !(vcount >= V_SYNC_START && vcount < V_SYNC_END);
			blank_n <= active;
		end
	end

	// x ramp on red, y ramp on green, leds on blue
	always_ff @(posedge clk_clk) begin
		r <= active ? color_t'(hcount) << 4 : '0;
		g <= active ? color_t'(vcount) << 5 : '0;
		b <= active ? color_t'(leds) : '0;
	end

endmodule

`default_nettype wire

//--- hw/platform.sv
`timescale 1ns/1ns
`default_nettype none

module platform
	import conspiracion_pkg::*;
(
	input  logic      clk_clk,
	input  logic      rst,

	input  logic      cpu_halt,
	input  logic      step,
	output logic      cpu_halted,

	input  logic      host_valid,
	output logic      host_ready,
	input  logic      host_write,
	input  bus_addr_t host_addr,
	input  bus_data_t host_wdata,
	output logic      host_rvalid,
	output bus_data_t host_rdata,

	input  bus_data_t switches,
	input  logic      button,
	output bus_data_t leds,

	output logic      vga_hsync,
	output logic      vga_vsync,
	output logic      vga_blank_n,
	output color_t    vga_r,
	output color_t    vga_g,
	output color_t    vga_b
);

	bus_if up_bus();
	bus_if down_bus();

	// host pins into the upstream bus
	assign up_bus.valid = host_valid;
	assign up_bus.write = host_write;
	assign up_bus.addr = host_addr;
	assign up_bus.wdata = host_wdata;
	assign host_ready = up_bus.ready;
	assign host_rvalid = up_bus.rvalid;
	assign host_rdata = up_bus.rdata;

	halt_gate gate
	(
		.up(up_bus.device),
		.down(down_bus.host),
		.*
	);

	pio_regs pio
	(
		.bus(down_bus.device),
		.*
	);

	vga_timing vga
	(
		.clk_clk(clk_clk),
		.rst(rst),
		.leds(leds),
		.hsync(vga_hsync),
		.vsync(vga_vsync),
		.blank_n(vga_blank_n),
		.r(vga_r),
		.g(vga_g),
		.b(vga_b)
	);

endmodule

`default_nettype wire

//--- hw/conspiracion.sv
`timescale 1ns/1ns
`default_nettype none

module conspiracion
	import conspiracion_pkg::*;
(
	input  logic      clk_clk,
	input  logic      rst,

	input  logic      halt,
	input  logic      step,
	output logic      cpu_halted,

	input  logic      host_valid,
	output logic      host_ready,
	input  logic      host_write,
	input  bus_addr_t host_addr,
	input  bus_data_t host_wdata,
	output logic      host_rvalid,
	output bus_data_t host_rdata,

	output bus_data_t pio_leds,
	input  logic      pio_buttons,
	input  logic [5:0] pio_switches,

	output logic      vga_dac_hsync,
	output logic      vga_dac_vsync,
	output logic      vga_dac_blank_n,
	output color_t    vga_dac_r,
	output color_t    vga_dac_g,
	output color_t    vga_dac_b
);

	logic cpu_halt, button;

	debounce halt_debounce
	(
		.clk_clk(clk_clk),
		.rst(rst),
		.dirty(halt),
		.clean(cpu_halt)
	);

	// button pin is active low, flip before filtering so reset reads as released
	debounce button_debounce
	(
		.clk_clk(clk_clk),
		.rst(rst),
		.dirty(!pio_buttons),
		.clean(button)
	);

	platform plat
	(
		.switches(bus_data_t'(pio_switches)),
		.leds(pio_leds),
		.vga_hsync(vga_dac_hsync),
		.vga_vsync(vga_dac_vsync),
		.vga_blank_n(vga_dac_blank_n),
		.vga_r(vga_dac_r),
		.vga_g(vga_dac_g),
		.vga_b(vga_dac_b),
		.*
	);

endmodule

`default_nettype wire

//--- verif/tb_conspiracion.sv
`timescale 1ns/1ns
`default_nettype none

`include "conspiracion_defines.svh"

module tb_conspiracion
	import conspiracion_pkg::*;
();

	localparam int LINE_CYCLES = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int FRAME_CYCLES = LINE_CYCLES * (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK);
	localparam int RESET_CYCLES = 10;
	localparam int SETTLE_CYCLES = 16;
	localparam int BUS_LIMIT = 32;
	localparam int HOLD_CYCLES = 8;
	localparam string STIM_FILE = "verif/conspiracion_stimulus.txt";

	logic clk_clk, rst, halt, step, cpu_halted;
	logic host_valid, host_ready, host_write, host_rvalid;
	bus_addr_t host_addr;
	bus_data_t host_wdata, host_rdata, pio_leds;
	logic pio_buttons;
	logic [5:0] pio_switches;
	logic vga_dac_hsync, vga_dac_vsync, vga_dac_blank_n;
	color_t vga_dac_r, vga_dac_g, vga_dac_b;

	logic [7:0] op_q[$];
	string name_q[$];
	logic [31:0] a_q[$], b_q[$], c_q[$];
	int n_cmds = 0;
	int checks = 0;
	int errors = 0;
	logic [31:0] rng = 32'h68ff663e;
	bus_data_t led_model;

	conspiracion uut (.*);

	initial begin
		clk_clk = 1'b0;
		forever #2 clk_clk = ~clk_clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		checks++;
		assert (got === exp)
		else begin
			errors++;
			$display("** Error %s: expected %0h, actual %0h", name, exp, got);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond)
		else begin
			errors++;
			$display("%s", what);
		end
	endtask

	task automatic load_stimulus();
		int fd, ch;
		logic [7:0] op_buf;
		logic [8*24-1:0] name_buf;
		logic [31:0] a, b, c;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("cannot open %s", STIM_FILE);
			return;
		end
		while ($fscanf(fd, "%s", op_buf) == 1) begin
			if (op_buf == "#") begin
				// skip the rest of a comment line
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1)
					ch = $fgetc(fd);
			end else if ($fscanf(fd, "%s %h %h %h", name_buf, a, b, c) == 4) begin
				op_q.push_back(op_buf);
				name_q.push_back(string'(name_buf));
				a_q.push_back(a);
				b_q.push_back(b);
				c_q.push_back(c);
			end else begin
				errors++;
				$display("stimulus entry %0d is malformed", op_q.size() + 1);
			end
		end
		$fclose(fd);
		n_cmds = op_q.size();
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_clk);
		@(negedge clk_clk);
		check_value("reset_ready", 0, 32'(host_ready));
		check_value("reset_rvalid", 0, 32'(host_rvalid));
		check_value("reset_halted", 0, 32'(cpu_halted));
		check_value("reset_leds", 0, 32'(pio_leds));
		check_value("reset_hsync", 1, 32'(vga_dac_hsync));
		check_value("reset_vsync", 1, 32'(vga_dac_vsync));
		check_value("reset_blank_n", 0, 32'(vga_dac_blank_n));
		rst = 1'b0;
	endtask

	task automatic start_request(input logic wr, input bus_addr_t addr, input bus_data_t data);
		@(negedge clk_clk);
		host_valid = 1'b1;
		host_write = wr;
		host_addr = addr;
		host_wdata = data;
	endtask

	// ends on the falling edge right after the transfer
	task automatic finish_request(input string name, output logic ok);
		int waited;
		waited = 0;
		#1;
		while (!host_ready && waited < BUS_LIMIT) begin
			@(negedge clk_clk);
			#1;
			waited++;
		end
		ok = host_ready;
		check_true(ok, $sformatf("%s: request not accepted within %0d cycles", name, BUS_LIMIT));
		@(negedge clk_clk);
		host_valid = 1'b0;
	endtask

	task automatic count_accepts(output int n);
		n = 0;
		repeat (HOLD_CYCLES) begin
			#1;
			if (host_ready)
				n++;
			@(negedge clk_clk);
		end
	endtask

	task automatic bus_write(input string name, input bus_addr_t addr, input bus_data_t data);
		logic ok;
		start_request(1'b1, addr, data);
		finish_request(name, ok);
		if (ok) begin
			check_value(name, 32'(led_model), 32'(pio_leds));
			check_value({name, "_rvalid"}, 0, 32'(host_rvalid));
		end
	endtask

	task automatic collect_read(input string name, input bus_data_t exp);
		int waited;
		waited = 0;
		while (!host_rvalid && waited < BUS_LIMIT) begin
			@(negedge clk_clk);
			waited++;
		end
		check_true(host_rvalid, $sformatf("%s: no read response within %0d cycles", name,
			BUS_LIMIT));
		if (host_rvalid)
			check_value(name, 32'(exp), 32'(host_rdata));
	endtask

	task automatic bus_read(input string name, input bus_addr_t addr, input bus_data_t exp);
		logic ok;
		start_request(1'b0, addr, '0);
		finish_request(name, ok);
		if (ok)
			collect_read(name, exp);
	endtask

	// a held request passes only on a step pulse
	task automatic step_read(input string name, input bus_addr_t addr, input bus_data_t exp);
		int early, late;
		logic ok;
		start_request(1'b0, addr, '0);
		count_accepts(early);
		check_true(early == 0, $sformatf("%s: request accepted while halted", name));
		step = 1'b1;
		@(negedge clk_clk);
		step = 1'b0;
		finish_request(name, ok);
		if (ok)
			collect_read(name, exp);
		start_request(1'b0, addr, '0);
		count_accepts(late);
		host_valid = 1'b0;
		check_true(late == 0, $sformatf("%s: second request passed on one step", name));
		check_value({name, "_halted"}, 1, 32'(cpu_halted));
	endtask

	task automatic check_frame(input string name, input int exp_hpulses, input int exp_vlow,
			input int exp_active);
		int waited, hpulses, hrun, vpulses, vlow, active, bad_width, bad_blue;
		int xpos, ypos, bad_red, bad_green, bad_dark;
		logic hs_prev, vs_prev;
		waited = 0;
		hpulses = 0;
		hrun = 0;
		vpulses = 0;
		vlow = 0;
		active = 0;
		bad_width = 0;
		bad_blue = 0;
		xpos = 0;
		ypos = 0;
		bad_red = 0;
		bad_green = 0;
		bad_dark = 0;
		// line up with the start of vsync
		vs_prev = vga_dac_vsync;
		@(negedge clk_clk);
		while (!(vs_prev && !vga_dac_vsync) && waited < 2 * FRAME_CYCLES) begin
			vs_prev = vga_dac_vsync;
			@(negedge clk_clk);
			waited++;
		end
		check_true(waited < 2 * FRAME_CYCLES, $sformatf("%s: no vsync within two frames", name));
		if (waited < 2 * FRAME_CYCLES) begin
			hs_prev = 1'b1;
			vs_prev = 1'b1;
			for (int i = 0; i < FRAME_CYCLES; i++) begin
				if (!vga_dac_vsync)
					vlow++;
				if (!vga_dac_vsync && vs_prev)
					vpulses++;
				if (!vga_dac_hsync) begin
					if (hs_prev)
						hpulses++;
					hrun++;
				end else if (!hs_prev) begin
					if (hrun != `H_SYNC)
						bad_width++;
					hrun = 0;
				end
				// active lines follow vsync in order, x ramp on red, y ramp on green
				if (vga_dac_blank_n) begin
					active++;
					if (vga_dac_b !== led_model)
						bad_blue++;
					if (vga_dac_r !== color_t'(xpos * 16))
						bad_red++;
					if (vga_dac_g !== color_t'(ypos * 32))
						bad_green++;
					xpos++;
				end else begin
					if ({vga_dac_r, vga_dac_g, vga_dac_b} !== 24'h0)
						bad_dark++;
					if (xpos != 0)
						ypos++;
					xpos = 0;
				end
				hs_prev = vga_dac_hsync;
				vs_prev = vga_dac_vsync;
				@(negedge clk_clk);
			end
			check_value({name, "_hsync_pulses"}, exp_hpulses, hpulses);
			check_value({name, "_hsync_bad_width"}, 0, bad_width);
			check_value({name, "_vsync_pulses"}, 1, vpulses);
			check_value({name, "_vsync_low"}, exp_vlow, vlow);
			check_value({name, "_active"}, exp_active, active);
			check_value({name, "_blue_mismatch"}, 0, bad_blue);
			check_value({name, "_red_mismatch"}, 0, bad_red);
			check_value({name, "_green_mismatch"}, 0, bad_green);
			check_value({name, "_blanked_colour"}, 0, bad_dark);
		end
	endtask

	task automatic run_command(input int i);
		string name;
		logic [31:0] a, b, c;
		bus_data_t data;
		name = name_q[i];
		a = a_q[i];
		b = b_q[i];
		c = c_q[i];
		data = (c != 0) ? led_model : b[7:0];
		case (op_q[i])
			"W": begin
				data = b[7:0];
				if (c != 0) begin
					rng = xorshift32(rng);
					data = rng[7:0];
				end
				if (a == `REG_LEDS)
					led_model = data;
				bus_write(name, bus_addr_t'(a), data);
			end
			"R":
				bus_read(name, bus_addr_t'(a), data);
			"S": begin
				pio_switches = a[5:0];
				repeat (SETTLE_CYCLES) @(negedge clk_clk);
			end
			"B": begin
				pio_buttons = a[0];
				repeat (SETTLE_CYCLES) @(negedge clk_clk);
			end
			"H": begin
				halt = a[0];
				repeat (SETTLE_CYCLES) @(negedge clk_clk);
				check_value(name, b, 32'(cpu_halted));
			end
			"P":
				step_read(name, bus_addr_t'(a), data);
			"V":
				check_frame(name, a, b, c);
			default: begin
				errors++;
				$display("%s: unknown opcode %c", name, op_q[i]);
			end
		endcase
	endtask

	initial begin : watchdog
		wait (n_cmds > 0);
		repeat (RESET_CYCLES + n_cmds * 200 + 3 * FRAME_CYCLES) @(posedge clk_clk);
		$display("watchdog expired, the run took longer than its %0d commands allow", n_cmds);
		$display("Regression failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		halt = 1'b0;
		step = 1'b0;
		host_valid = 1'b0;
		host_write = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		pio_buttons = 1'b1;
		pio_switches = '0;
		led_model = '0;
		load_stimulus();
		if (n_cmds == 0) begin
			$display("no commands were read from the stimulus file");
			$display("Regression failed");
			$finish;
		end else begin
			apply_reset();
			for (int i = 0; i < n_cmds; i++)
				run_command(i);
			repeat (4) @(negedge clk_clk);
			$display("checks: %0d, errors: %0d", checks, errors);
			if (errors == 0)
				$display("Regression passed");
			else
				$display("Regression failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- conspiracion.f
+incdir+hw
hw/conspiracion_pkg.sv
hw/bus_if.sv
hw/debounce.sv
hw/halt_gate.sv
hw/pio_regs.sv
hw/vga_timing.sv
hw/platform.sv
hw/conspiracion.sv
verif/tb_conspiracion.sv

//--- Makefile
TOP = tb_conspiracion

.PHONY: all run lint clean

all: run

# build, run, and pass only if the pass line shows up in the output
run:
	verilator --binary --timing --assert -f conspiracion.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Regression passed"

lint:
	verilator --lint-only --timing -Wall -f conspiracion.f --top-module conspiracion

clean:
	rm -rf obj_dir

//--- verif/conspiracion_stimulus.txt
# op name a b c, fields in hex; W addr data random, R and P addr expected use_model
# S switches, B button_pin, H halt expected_halted, V hsync_pulses vsync_low active
W led_fixed 0 a5 0
R led_fixed_rd 0 a5 0
W led_rand 0 0 1
R led_rand_rd 0 0 1
W sw_addr_write 1 ff 0
R led_kept 0 0 1
S sw_all ff 0 0
R sw_all_rd 1 3f 0
S sw_pattern 95 0 0
R sw_pattern_rd 1 15 0
R btn_idle 2 0 0
B btn_press 0 0 0
R btn_pressed 2 3 0
B btn_release 1 0 0
R btn_sticky 2 2 0
W btn_clear 2 2 0
R btn_cleared 2 0 0
W led_rand2 0 0 1
V frame_1 c 30 80
H halt_on 1 1 0
P step_led 0 0 1
P step_sw 1 15 0
P step_btn 2 0 0
H halt_off 0 0 0
R run_again 0 0 1
W led_rand3 0 0 1
R led_rand3_rd 0 0 1
V frame_2 c 30 80
